// ==== flist.f ====
+incdir+.
riscv_pkg.sv
thread_pc_file.sv
control_unit.sv
regfile_bank.sv
execute_unit.sv
riscv_core.sv
riscv_core_assert.sv
tb_riscv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_riscv_core \
  -f flist.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// ==== tb_riscv_core.sv ====
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module tb_riscv_core;
  import riscv_pkg::*;

  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;

  logic       clk;
  logic       reset;
  word_t      imem_data;
  word_t      dmem_rdata;
  imem_addr_t imem_addr;
  dmem_req_s  dmem_req;
  wb_s        wb;

  // ROM shared by all threads
  word_t rom  [1 << `RV_IMEM_AW];
  // Word-addressed data memory
  word_t dmem [1 << `RV_DMEM_AW];

  // Expected writebacks in program order and expected stores
  wb_s       exp_wb [$];
  dmem_req_s exp_st [$];
  int        n_prog;
  int        wb_idx;
  int        st_idx;
  int        wb_errors;
  int        st_errors;
  int        other_errors;
  int        cycles;
  int        limit;
  logic      timed_out;
  wb_s       wb_ref;
  dmem_req_s st_ref;

  // Branch operand registers with x1 holding -8 and x4 holding 5
  logic [2:0] br_f3  [6];
  reg_addr_t  tk_rs1 [6];
  reg_addr_t  tk_rs2 [6];
  reg_addr_t  nt_rs1 [6];
  reg_addr_t  nt_rs2 [6];

  riscv_core dut0 (
    .clk         (clk),
    .reset       (reset),
    .i_imem_data (imem_data),
    .i_dmem_rdata(dmem_rdata),
    .o_imem_addr (imem_addr),
    .o_dmem      (dmem_req),
    .o_wb        (wb)
  );

  always #2 clk = ~clk;

  // Combinational ROM and memory read
  assign imem_data  = rom[imem_addr];
  assign dmem_rdata = dmem[dmem_req.addr];

  always @(posedge clk) begin
    if (dmem_req.we) begin
      dmem[dmem_req.addr] <= dmem_req.wdata;
    end
  end

  // ---------------------------------------------------------------------------
  // RV32I encoders
  // ---------------------------------------------------------------------------
  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Append one instruction and its optional writeback
  task automatic add_instr(input word_t instr, input logic has_wb, input reg_addr_t rd,
                           input word_t data);
    wb_s e;
    rom[n_prog] = instr;
    n_prog++;
    if (has_wb) begin
      e = '{en: 1'b1, thread: '0, rd: rd, data: data};
      exp_wb.push_back(e);
    end
  endtask

  task automatic add_store(input dmem_addr_t addr, input word_t data);
    dmem_req_s e;
    e = '{addr: addr, wdata: data, we: 1'b1};
    exp_st.push_back(e);
  endtask

  // ---------------------------------------------------------------------------
  // Typed compares
  // ---------------------------------------------------------------------------
  task automatic check_wb(input wb_s got, input wb_s exp);
    if (got !== exp) begin
      wb_errors++;
      $display("error %0t: writeback t%0d x%0d=%h, expected t%0d x%0d=%h", $time,
               got.thread, got.rd, got.data, exp.thread, exp.rd, exp.data);
    end
  endtask

  task automatic check_store(input dmem_req_s got, input dmem_req_s exp);
    if (got !== exp) begin
      st_errors++;
      $display("error %0t: store addr %h data %h, expected addr %h data %h", $time,
               got.addr, got.wdata, exp.addr, exp.wdata);
    end
  endtask

  // Entry k is seen four times for threads 0..3 on back-to-back slots
  always @(negedge clk) begin
    if (!reset) begin
      if (wb.en) begin
        if (wb_idx < 4 * exp_wb.size()) begin
          wb_ref        = exp_wb[wb_idx / 4];
          wb_ref.thread = thread_t'(wb_idx % 4);
          check_wb(wb, wb_ref);
        end else begin
          other_errors++;
          $display("extra writeback at %0t to x%0d", $time, wb.rd);
        end
        wb_idx++;
      end
      if (dmem_req.we) begin
        if (st_idx < 4 * exp_st.size()) begin
          st_ref = exp_st[st_idx / 4];
          check_store(dmem_req, st_ref);
        end else begin
          other_errors++;
          $display("extra store at %0t to word %h", $time, dmem_req.addr);
        end
        st_idx++;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Program build and run
  // ---------------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    reset = 1'b1;
    n_prog = 0;
    wb_idx = 0;
    st_idx = 0;
    wb_errors = 0;
    st_errors = 0;
    other_errors = 0;
    cycles = 0;
    timed_out = 1'b0;
    // Unused ROM words hold opcode zero with the address in the upper bits
    for (int a = 0; a < (1 << `RV_IMEM_AW); a++) begin
      rom[a] = {10'(a), 22'h0};
    end
    for (int a = 0; a < (1 << `RV_DMEM_AW); a++) begin
      dmem[a] = 32'(a) * 32'h9e37_79b1;
    end
    br_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    tk_rs1 = '{5'd4, 5'd4, 5'd1, 5'd4, 5'd4, 5'd1};
    tk_rs2 = '{5'd4, 5'd1, 5'd4, 5'd1, 5'd1, 5'd4};
    nt_rs1 = '{5'd4, 5'd4, 5'd4, 5'd1, 5'd1, 5'd4};
    nt_rs2 = '{5'd1, 5'd4, 5'd1, 5'd4, 5'd4, 5'd1};

    // ALU, LUI and AUIPC
    add_instr(i_type(12'hff8, 5'd0, 3'd0, 5'd1, OPC_OPIMM), 1'b1, 5'd1, 32'hffff_fff8);
    add_instr(i_type(12'h401, 5'd1, 3'd5, 5'd2, OPC_OPIMM), 1'b1, 5'd2, 32'hffff_fffc);
    add_instr(i_type(12'h001, 5'd1, 3'd5, 5'd3, OPC_OPIMM), 1'b1, 5'd3, 32'h7fff_fffc);
    add_instr(i_type(12'h005, 5'd0, 3'd0, 5'd4, OPC_OPIMM), 1'b1, 5'd4, 32'd5);
    add_instr(r_type(7'h00, 5'd4, 5'd1, 3'd2, 5'd5), 1'b1, 5'd5, 32'd1);
    add_instr(r_type(7'h00, 5'd4, 5'd1, 3'd3, 5'd6), 1'b1, 5'd6, 32'd0);
    add_instr(r_type(7'h20, 5'd1, 5'd4, 3'd0, 5'd7), 1'b1, 5'd7, 32'd13);
    add_instr(u_type(20'h12345, 5'd8, OPC_LUI), 1'b1, 5'd8, 32'h1234_5000);
    add_instr(u_type(20'h00001, 5'd9, OPC_AUIPC), 1'b1, 5'd9, 32'(n_prog * 4) + 32'h1000);
    add_instr(r_type(7'h00, 5'd4, 5'd1, 3'd4, 5'd10), 1'b1, 5'd10, 32'hffff_fffd);
    add_instr(r_type(7'h00, 5'd4, 5'd1, 3'd7, 5'd11), 1'b1, 5'd11, 32'd0);
    add_instr(r_type(7'h00, 5'd4, 5'd1, 3'd6, 5'd12), 1'b1, 5'd12, 32'hffff_fffd);
    add_instr(r_type(7'h00, 5'd4, 5'd4, 3'd1, 5'd19), 1'b1, 5'd19, 32'h0000_00a0);
    add_instr(i_type(12'hfff, 5'd1, 3'd4, 5'd20, OPC_OPIMM), 1'b1, 5'd20, 32'd7);
    add_instr(i_type(12'h001, 5'd1, 3'd2, 5'd21, OPC_OPIMM), 1'b1, 5'd21, 32'd1);
    add_instr(i_type(12'h001, 5'd1, 3'd3, 5'd22, OPC_OPIMM), 1'b1, 5'd22, 32'd0);

    // Not-taken branch falls onto a marker and taken branch skips a poison write
    for (int c = 0; c < 6; c++) begin
      add_instr(b_type(13'd8, nt_rs2[c], nt_rs1[c], br_f3[c]), 1'b0, 5'd0, 32'd0);
      add_instr(i_type(12'(c + 1), 5'd0, 3'd0, 5'd13, OPC_OPIMM), 1'b1, 5'd13, 32'(c + 1));
      add_instr(b_type(13'd8, tk_rs2[c], tk_rs1[c], br_f3[c]), 1'b0, 5'd0, 32'd0);
      add_instr(i_type(12'hfff, 5'd0, 3'd0, 5'd13, OPC_OPIMM), 1'b0, 5'd0, 32'd0);
    end

    // JAL over one word and then JALR to an odd target
    add_instr(j_type(21'd8, 5'd14), 1'b1, 5'd14, 32'((n_prog + 1) * 4));
    add_instr(i_type(12'hfff, 5'd0, 3'd0, 5'd13, OPC_OPIMM), 1'b0, 5'd0, 32'd0);
    add_instr(i_type(12'((n_prog + 3) * 4 + 1), 5'd0, 3'd0, 5'd16, OPC_OPIMM), 1'b1, 5'd16,
              32'((n_prog + 3) * 4 + 1));
    add_instr(i_type(12'h000, 5'd16, 3'd0, 5'd17, OPC_JALR), 1'b1, 5'd17,
              32'((n_prog + 1) * 4));
    add_instr(i_type(12'hfff, 5'd0, 3'd0, 5'd13, OPC_OPIMM), 1'b0, 5'd0, 32'd0);
    // AUIPC at the JALR target exposes an odd PC
    add_instr(u_type(20'h00000, 5'd24, OPC_AUIPC), 1'b1, 5'd24, 32'(n_prog * 4));

    // Word store then load back
    add_instr(s_type(12'd16, 5'd7, 5'd0), 1'b0, 5'd0, 32'd0);
    add_store(dmem_addr_t'(16 / 4), 32'd13);
    add_instr(i_type(12'd16, 5'd0, 3'd2, 5'd18, OPC_LOAD), 1'b1, 5'd18, 32'd13);
    add_instr(s_type(12'd64, 5'd8, 5'd0), 1'b0, 5'd0, 32'd0);
    add_store(dmem_addr_t'(64 / 4), 32'h1234_5000);
    add_instr(i_type(12'd64, 5'd0, 3'd2, 5'd23, OPC_LOAD), 1'b1, 5'd23, 32'h1234_5000);
    // Park every thread
    add_instr(j_type(21'd0, 5'd0), 1'b0, 5'd0, 32'd0);

    limit = 4 * (n_prog + 8);
    repeat (8) @(negedge clk);
    reset = 1'b0;

    while (!(wb_idx == 4 * exp_wb.size() && st_idx == 4 * exp_st.size()) &&
           cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= limit) begin
      timed_out = 1'b1;
      $display("timeout after %0d cycles, %0d writebacks and %0d stores seen",
               cycles, wb_idx, st_idx);
    end
    // Parked threads must stay silent in the tail
    repeat (8) @(negedge clk);

    $display("writeback errors %0d, store errors %0d, other errors %0d, timeout %0d",
             wb_errors, st_errors, other_errors, timed_out);
    if (wb_errors == 0 && st_errors == 0 && other_errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end
endmodule

// ==== riscv_core_assert.sv ====
`timescale 1ns/1ps

module riscv_core_assert (
  input logic                 clk,
  input logic                 reset,
  input riscv_pkg::wb_s       i_wb,
  input riscv_pkg::dmem_req_s i_dmem,
  input riscv_pkg::thread_t   i_fetch_thread
);
  import riscv_pkg::*;

  // Pipeline drained once reset has been held for a cycle
  assert property (@(posedge clk) (reset && $past(reset)) |-> (!i_wb.en && !i_dmem.we))
    else $error("writeback or store seen while reset is held");

  // Round-robin issue, one thread step per cycle
  assert property (@(posedge clk) disable iff (reset)
                   1'b1 |=> i_fetch_thread == thread_t'($past(i_fetch_thread) + 1'b1))
    else $error("fetch thread did not advance by one");

  // x0 is never a writeback target
  assert property (@(posedge clk) disable iff (reset) i_wb.en |-> (i_wb.rd != '0))
    else $error("writeback strobe with rd equal to zero");
endmodule

bind riscv_core riscv_core_assert u_assert (
  .clk           (clk),
  .reset         (reset),
  .i_wb          (o_wb),
  .i_dmem        (o_dmem),
  .i_fetch_thread(fetch_thread)
);

// ==== riscv_core.sv ====
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_core (
  input  logic                  clk,
  input  logic                  reset,
  input  riscv_pkg::word_t      i_imem_data,
  input  riscv_pkg::word_t      i_dmem_rdata,
  output riscv_pkg::imem_addr_t o_imem_addr,
  output riscv_pkg::dmem_req_s  o_dmem,
  output riscv_pkg::wb_s        o_wb
);
  import riscv_pkg::*;

  // Stage payloads, valid bits kept apart
  typedef struct packed {
    thread_t thread;
    word_t   instr;
    word_t   pc;
  } fd_s;

  typedef struct packed {
    thread_t   thread;
    ctrl_s     ctrl;
    word_t     imm;
    word_t     rd1;
    word_t     rd2;
    reg_addr_t rd;
    word_t     pc;
  } de_s;

  typedef struct packed {
    thread_t   thread;
    word_t     result;
    word_t     pc_plus4;
    reg_addr_t rd;
    wb_sel_e   wb_sel;
    logic      reg_we;
  } ew_s;

  thread_t    fetch_thread;
  word_t      fetch_pc;
  logic       fd_valid;
  logic       de_valid;
  logic       ew_valid;
  fd_s        fd_q;
  de_s        de_q;
  ew_s        ew_q;
  ctrl_s      dec_ctrl;
  word_t      dec_imm;
  reg_addr_t  dec_rs1;
  reg_addr_t  dec_rs2;
  reg_addr_t  dec_rd;
  word_t      rf_rd1;
  word_t      rf_rd2;
  word_t      ex_result;
  word_t      ex_next_pc;
  word_t      ex_pc_plus4;
  logic       dmem_we_q;
  dmem_addr_t dmem_addr_q;
  word_t      dmem_wdata_q;
  word_t      wb_data;

  // ---------------------------------------------------------------------------
  // Fetch
  // ---------------------------------------------------------------------------
  // PC written back by execute two cycles after the fetch
  thread_pc_file u_pc (
    .clk           (clk),
    .reset         (reset),
    .i_pc_we       (de_valid),
    .i_pc_thread   (de_q.thread),
    .i_next_pc     (ex_next_pc),
    .o_fetch_thread(fetch_thread),
    .o_fetch_pc    (fetch_pc)
  );

  // ROM is word addressed
  assign o_imem_addr = fetch_pc[`RV_IMEM_AW+1:2];

  // ---------------------------------------------------------------------------
  // Decode
  // ---------------------------------------------------------------------------
  control_unit u_ctrl (
    .i_instr(fd_q.instr),
    .o_ctrl (dec_ctrl),
    .o_imm  (dec_imm),
    .o_rs1  (dec_rs1),
    .o_rs2  (dec_rs2),
    .o_rd   (dec_rd)
  );

  // Same thread last wrote at least two cycles ago, no bypass
  regfile_bank u_rf (
    .clk        (clk),
    .i_rd_thread(fd_q.thread),
    .i_rs1      (dec_rs1),
    .i_rs2      (dec_rs2),
    .i_we       (o_wb.en),
    .i_wr_thread(o_wb.thread),
    .i_wr_addr  (o_wb.rd),
    .i_wr_data  (o_wb.data),
    .o_rd1      (rf_rd1),
    .o_rd2      (rf_rd2)
  );

  // ---------------------------------------------------------------------------
  // Execute
  // ---------------------------------------------------------------------------
  execute_unit u_exe (
    .i_ctrl    (de_q.ctrl),
    .i_pc      (de_q.pc),
    .i_rd1     (de_q.rd1),
    .i_rd2     (de_q.rd2),
    .i_imm     (de_q.imm),
    .o_result  (ex_result),
    .o_next_pc (ex_next_pc),
    .o_pc_plus4(ex_pc_plus4)
  );

  // ---------------------------------------------------------------------------
  // Pipeline registers
  // ---------------------------------------------------------------------------
  // Fetch starts the cycle after reset and never stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      fd_valid  <= 1'b0;
      de_valid  <= 1'b0;
      ew_valid  <= 1'b0;
      dmem_we_q <= 1'b0;
    end else begin
      fd_valid  <= 1'b1;
      de_valid  <= fd_valid;
      ew_valid  <= de_valid;
      dmem_we_q <= de_valid & de_q.ctrl.mem_wr;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    fd_q.thread     <= fetch_thread;
    fd_q.instr      <= i_imem_data;
    fd_q.pc         <= fetch_pc;
    de_q.thread     <= fd_q.thread;
    de_q.ctrl       <= dec_ctrl;
    de_q.imm        <= dec_imm;
    de_q.rd1        <= rf_rd1;
    de_q.rd2        <= rf_rd2;
    de_q.rd         <= dec_rd;
    de_q.pc         <= fd_q.pc;
    ew_q.thread     <= de_q.thread;
    ew_q.result     <= ex_result;
    ew_q.pc_plus4   <= ex_pc_plus4;
    ew_q.rd         <= de_q.rd;
    ew_q.wb_sel     <= de_q.ctrl.wb_sel;
    ew_q.reg_we     <= de_q.ctrl.reg_we;
    // Memory word address from ALU result
    dmem_addr_q     <= ex_result[`RV_DMEM_AW+1:2];
    dmem_wdata_q    <= de_q.rd2;
  end

  // ---------------------------------------------------------------------------
  // Memory and writeback
  // ---------------------------------------------------------------------------
  assign o_dmem = '{addr: dmem_addr_q, wdata: dmem_wdata_q, we: dmem_we_q};

  // Load data returns in the same cycle as the request
  always_comb begin
    case (ew_q.wb_sel)
      WB_MEM:  wb_data = i_dmem_rdata;
      WB_PC4:  wb_data = ew_q.pc_plus4;
      default: wb_data = ew_q.result;
    endcase
  end

  assign o_wb = '{en:     ew_valid & ew_q.reg_we,
                  thread: ew_q.thread,
                  rd:     ew_q.rd,
                  data:   wb_data};
endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  riscv_pkg::ctrl_s i_ctrl,
  input  riscv_pkg::word_t i_pc,
  input  riscv_pkg::word_t i_rd1,
  input  riscv_pkg::word_t i_rd2,
  input  riscv_pkg::word_t i_imm,
  output riscv_pkg::word_t o_result,
  output riscv_pkg::word_t o_next_pc,
  output riscv_pkg::word_t o_pc_plus4
);
  import riscv_pkg::*;

  word_t      op1;
  word_t      op2;
  word_t      alu_out;
  logic [4:0] shamt;
  logic       taken;

  // ---------------------------------------------------------------------------
  // Operand select and ALU
  // ---------------------------------------------------------------------------
  assign op1   = i_ctrl.op1_pc  ? i_pc  : i_rd1;
  assign op2   = i_ctrl.op2_imm ? i_imm : i_rd2;
  // Shift amount is the low five bits
  assign shamt = op2[4:0];

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:  alu_out = op1 + op2;
      ALU_SUB:  alu_out = op1 - op2;
      ALU_AND:  alu_out = op1 & op2;
      ALU_OR:   alu_out = op1 | op2;
      ALU_XOR:  alu_out = op1 ^ op2;
      ALU_SLL:  alu_out = op1 << shamt;
      ALU_SRL:  alu_out = op1 >> shamt;
      ALU_SRA:  alu_out = word_t'($signed(op1) >>> shamt);
      ALU_SLT:  alu_out = word_t'($signed(op1) < $signed(op2));
      ALU_SLTU: alu_out = word_t'(op1 < op2);
      // LUI passes the U immediate through
      default:  alu_out = op2;
    endcase
  end

  // JALR target drops bit 0
  assign o_result = alu_out & ~word_t'(i_ctrl.jalr_clear_lsb);

  // ---------------------------------------------------------------------------
  // Branch resolution
  // ---------------------------------------------------------------------------
  always_comb begin
    case (i_ctrl.funct3)
      3'b000:  taken = (i_rd1 == i_rd2);
      3'b001:  taken = (i_rd1 != i_rd2);
      3'b100:  taken = ($signed(i_rd1) <  $signed(i_rd2));
      3'b101:  taken = ($signed(i_rd1) >= $signed(i_rd2));
      3'b110:  taken = (i_rd1 <  i_rd2);
      3'b111:  taken = (i_rd1 >= i_rd2);
      default: taken = 1'b0;
    endcase
  end

  // Sequential PC, also the link value
  assign o_pc_plus4 = i_pc + word_t'(4);

  // Redirect on taken branch or any jump
  assign o_next_pc = ((i_ctrl.is_branch & taken) | i_ctrl.is_jump) ? o_result
                                                                    : o_pc_plus4;
endmodule

// ==== regfile_bank.sv ====
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module regfile_bank (
  input  logic                 clk,
  input  riscv_pkg::thread_t   i_rd_thread,
  input  riscv_pkg::reg_addr_t i_rs1,
  input  riscv_pkg::reg_addr_t i_rs2,
  input  logic                 i_we,
  input  riscv_pkg::thread_t   i_wr_thread,
  input  riscv_pkg::reg_addr_t i_wr_addr,
  input  riscv_pkg::word_t     i_wr_data,
  output riscv_pkg::word_t     o_rd1,
  output riscv_pkg::word_t     o_rd2
);
  import riscv_pkg::*;

  // One 32-entry bank per thread
  word_t regs [`RV_NUM_THREADS][32];

  // Single write port, thread taken from writeback
  always_ff @(posedge clk) begin
    if (i_we) begin
      regs[i_wr_thread][i_wr_addr] <= i_wr_data;
    end
  end

  // Async reads for decode, x0 forced to zero
  assign o_rd1 = (i_rs1 == '0) ? '0 : regs[i_rd_thread][i_rs1];
  assign o_rd2 = (i_rs2 == '0) ? '0 : regs[i_rd_thread][i_rs2];
endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  riscv_pkg::word_t     i_instr,
  output riscv_pkg::ctrl_s     o_ctrl,
  output riscv_pkg::word_t     o_imm,
  output riscv_pkg::reg_addr_t o_rs1,
  output riscv_pkg::reg_addr_t o_rs2,
  output riscv_pkg::reg_addr_t o_rd
);
  import riscv_pkg::*;

  // RV32I major opcodes in use
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // Funct3 picks the operation, alt selects sub or sra
  function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ---------------------------------------------------------------------------
  // Field split
  // ---------------------------------------------------------------------------
  assign opcode = i_instr[6:0];
  assign o_rd   = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];
  assign funct7 = i_instr[31:25];

  // Sign-extended immediate formats
  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  // ---------------------------------------------------------------------------
  // Control generation
  // ---------------------------------------------------------------------------
  always_comb begin
    // Unknown opcodes fall out as a bubble
    o_ctrl        = '0;
    o_ctrl.alu_op = ALU_ADD;
    o_ctrl.wb_sel = WB_ALU;
    o_ctrl.funct3 = funct3;
    o_imm         = imm_i;
    case (opcode)
      OPC_LUI: begin
        o_ctrl.alu_op  = ALU_PASS2;
        o_ctrl.op2_imm = 1'b1;
        o_ctrl.reg_we  = 1'b1;
        o_imm          = imm_u;
      end
      OPC_AUIPC: begin
        o_ctrl.op1_pc  = 1'b1;
        o_ctrl.op2_imm = 1'b1;
        o_ctrl.reg_we  = 1'b1;
        o_imm          = imm_u;
      end
      // Jumps compute the target in the ALU, link is pc+4
      OPC_JAL: begin
        o_ctrl.op1_pc  = 1'b1;
        o_ctrl.op2_imm = 1'b1;
        o_ctrl.is_jump = 1'b1;
        o_ctrl.reg_we  = 1'b1;
        o_ctrl.wb_sel  = WB_PC4;
        o_imm          = imm_j;
      end
      OPC_JALR: begin
        o_ctrl.op2_imm        = 1'b1;
        o_ctrl.is_jump        = 1'b1;
        o_ctrl.jalr_clear_lsb = 1'b1;
        o_ctrl.reg_we         = 1'b1;
        o_ctrl.wb_sel         = WB_PC4;
      end
      // Target pc+imm, compare done on rd1/rd2
      OPC_BRANCH: begin
        o_ctrl.op1_pc    = 1'b1;
        o_ctrl.op2_imm   = 1'b1;
        o_ctrl.is_branch = 1'b1;
        o_imm            = imm_b;
      end
      OPC_LOAD: begin
        o_ctrl.op2_imm = 1'b1;
        o_ctrl.reg_we  = 1'b1;
        o_ctrl.wb_sel  = WB_MEM;
      end
      OPC_STORE: begin
        o_ctrl.op2_imm = 1'b1;
        o_ctrl.mem_wr  = 1'b1;
        o_imm          = imm_s;
      end
      // Only shifts read funct7 among immediate ops
      OPC_OPIMM: begin
        o_ctrl.alu_op  = decode_alu(funct3, funct7[5] & (funct3 == 3'b101));
        o_ctrl.op2_imm = 1'b1;
        o_ctrl.reg_we  = 1'b1;
      end
      OPC_OP: begin
        o_ctrl.alu_op = decode_alu(funct3, funct7[5]);
        o_ctrl.reg_we = 1'b1;
      end
      default: o_ctrl.reg_we = 1'b0;
    endcase
    // x0 is never written
    if (o_rd == '0) begin
      o_ctrl.reg_we = 1'b0;
    end
  end
endmodule

// ==== thread_pc_file.sv ====
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module thread_pc_file (
  input  logic               clk,
  input  logic               reset,
  input  logic               i_pc_we,
  input  riscv_pkg::thread_t i_pc_thread,
  input  riscv_pkg::word_t   i_next_pc,
  output riscv_pkg::thread_t o_fetch_thread,
  output riscv_pkg::word_t   o_fetch_pc
);
  import riscv_pkg::*;

  // Thread selected for fetch this cycle
  thread_t thread_q;
  // One PC slot per thread
  word_t   pc_q [`RV_NUM_THREADS];

  // Round-robin counter, wraps on its own width
  always_ff @(posedge clk) begin
    if (reset) begin
      thread_q <= '0;
    end else begin
      thread_q <= thread_q + thread_t'(1);
    end
  end

  // Next PC from execute lands in the executing thread's slot
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int t = 0; t < `RV_NUM_THREADS; t++) begin
        pc_q[t] <= '0;
      end
    end else if (i_pc_we) begin
      pc_q[i_pc_thread] <= i_next_pc;
    end
  end

  assign o_fetch_thread = thread_q;
  assign o_fetch_pc     = pc_q[thread_q];
endmodule

// ==== riscv_pkg.sv ====
`include "riscv_cfg.svh"

package riscv_pkg;

  // Plain vectors with a meaning
  typedef logic [`RV_XLEN-1:0]                word_t;
  typedef logic [4:0]                         reg_addr_t;
  typedef logic [$clog2(`RV_NUM_THREADS)-1:0] thread_t;
  typedef logic [`RV_IMEM_AW-1:0]             imem_addr_t;
  typedef logic [`RV_DMEM_AW-1:0]             dmem_addr_t;

  // ALU operations, PASS2 forwards operand 2 for LUI
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,
    ALU_SLTU  = 4'd9,
    ALU_PASS2 = 4'd10
  } alu_op_e;

  // Writeback source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

  // Decoded control word
  typedef struct packed {
    alu_op_e    alu_op;
    logic       op1_pc;
    logic       op2_imm;
    logic       is_branch;
    logic       is_jump;
    logic       jalr_clear_lsb;
    logic [2:0] funct3;
    logic       mem_wr;
    logic       reg_we;
    wb_sel_e    wb_sel;
  } ctrl_s;

  // Data memory request, word addressed
  typedef struct packed {
    dmem_addr_t addr;
    word_t      wdata;
    logic       we;
  } dmem_req_s;

  // Register writeback, also the observation port
  typedef struct packed {
    logic      en;
    thread_t   thread;
    reg_addr_t rd;
    word_t     data;
  } wb_s;

endpackage

// ==== riscv_cfg.svh ====
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// ---------------------------------------------------------------------------
// Core sizing
// ---------------------------------------------------------------------------

// Hardware threads, kept a power of two
`define RV_NUM_THREADS 4

// Data word and PC width
`define RV_XLEN 32

// Instruction ROM word address bits
`define RV_IMEM_AW 10

// Data memory word address bits
`define RV_DMEM_AW 14

`endif
